//--- design/stream_pkg.sv
package stream_pkg;

    // ========================================================================
    // word and bus widths
    // ========================================================================

    typedef logic [15:0] data_t;
    typedef logic [7:0]  wb_adr_t;
    typedef logic [15:0] wb_dat_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    // broadcast to every lane
    typedef struct packed {
        data_t coeff;
        data_t offset;
    } lane_cfg_t;

    // one operand write, already split into lane and word
    typedef struct packed {
        logic       en;
        logic [7:0] lane;
        logic [7:0] word;
        data_t      data;
    } op_wr_t;

    // ========================================================================
    // register map
    // ========================================================================

    localparam wb_adr_t REG_CTRL   = 8'h00;
    localparam wb_adr_t REG_COEFF  = 8'h01;
    localparam wb_adr_t REG_OFFSET = 8'h02;
    // flat operand window, operand k at REG_OPBASE + k
    localparam wb_adr_t REG_OPBASE = 8'h40;

    // bit positions inside REG_CTRL
    localparam int CTRL_START = 0;
    localparam int CTRL_BUSY  = 1;
    localparam int CTRL_DONE  = 2;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_RUN,
        LANE_FIN
    } lane_state_t;

endpackage

//--- design/agu.sv
`timescale 1ns/10ps

module agu #(
    parameter int W        = 8,
    parameter int LAST_IDX = 0
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         en,
    output logic [W-1:0] data,
    output logic         last
);

    // final count in the counter's own width
    localparam logic [W-1:0] FINAL_IDX = W'(LAST_IDX);

    logic [W-1:0] idx;
    // armed between start and the last step
    logic         run;

    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
            run <= 1'b0;
        end else if (start) begin
            // restart from zero
            idx <= '0;
            run <= 1'b1;
        end else if (en && run) begin
            if (idx == FINAL_IDX) begin
                // stop here, index stays at the final count
                run <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    assign data = idx;
    // only while armed, so a finished counter does not look like a new last
    assign last = run && (idx == FINAL_IDX);

endmodule

//--- design/wb_regs.sv
`timescale 1ns/10ps

module wb_regs #(
    parameter int NUM_CORES      = 4,
    parameter int WORDS_PER_CORE = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  stream_pkg::wb_req_t   wb_req,
    output stream_pkg::wb_rsp_t   wb_rsp,
    input  logic                  stream_done,
    output logic                  start,
    output stream_pkg::lane_cfg_t cfg,
    output stream_pkg::op_wr_t    op_wr
);

    import stream_pkg::*;

    localparam int      TOTAL = NUM_CORES * WORDS_PER_CORE;
    localparam wb_adr_t WPC_A = wb_adr_t'(WORDS_PER_CORE);
    localparam wb_adr_t TOT_A = wb_adr_t'(TOTAL);

    logic    ack_q;
    wb_dat_t rdat_q;
    data_t   coeff_q;
    data_t   offset_q;
    logic    busy_q;
    logic    done_q;
    logic    start_q;
    op_wr_t  op_wr_q;

    logic    acc;
    logic    wr;
    wb_adr_t op_k;
    logic    op_hit;
    wb_dat_t rd_mux;

    // ========================================================================
    // access decode
    // ========================================================================

    // new access only while ack is low, so one ack per cyc/stb
    assign acc = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr  = acc & wb_req.we;

    // flat operand index and window check
    assign op_k   = wb_req.adr - REG_OPBASE;
    assign op_hit = (wb_req.adr >= REG_OPBASE) && (op_k < TOT_A);

    always_comb begin
        rd_mux = '0;
        case (wb_req.adr)
            REG_CTRL: begin
                rd_mux[CTRL_BUSY] = busy_q;
                rd_mux[CTRL_DONE] = done_q;
            end
            REG_COEFF:  rd_mux = coeff_q;
            REG_OFFSET: rd_mux = offset_q;
            // operand window reads as zero
            default:    rd_mux = '0;
        endcase
    end

    // ========================================================================
    // control state
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q    <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            start_q  <= 1'b0;
            op_wr_q.en <= 1'b0;
        end else begin
            ack_q      <= acc;
            start_q    <= 1'b0;
            op_wr_q.en <= wr & op_hit;
            // start only from idle, a start while busy is dropped
            if (wr && (wb_req.adr == REG_CTRL) && wb_req.dat[CTRL_START] && !busy_q) begin
                start_q <= 1'b1;
                busy_q  <= 1'b1;
                done_q  <= 1'b0;
            end else if (stream_done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // payload side
    always_ff @(posedge clk) begin
        if (acc) begin
            rdat_q <= rd_mux;
        end
        if (wr && (wb_req.adr == REG_COEFF)) begin
            coeff_q <= wb_req.dat;
        end
        if (wr && (wb_req.adr == REG_OFFSET)) begin
            offset_q <= wb_req.dat;
        end
        // lane = k / words, word = k mod words
        op_wr_q.lane <= op_k / WPC_A;
        op_wr_q.word <= op_k % WPC_A;
        op_wr_q.data <= wb_req.dat;
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;
    assign start      = start_q;
    assign cfg.coeff  = coeff_q;
    assign cfg.offset = offset_q;
    assign op_wr      = op_wr_q;

endmodule

//--- design/core_lane.sv
`timescale 1ns/10ps

module core_lane #(
    parameter int LANE_ID        = 0,
    parameter int WORDS_PER_CORE = 4
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     start,
    input  stream_pkg::lane_cfg_t                    cfg,
    input  stream_pkg::op_wr_t                       op_wr,
    output logic                                     fin,
    output stream_pkg::data_t [WORDS_PER_CORE-1:0]   results
);

    import stream_pkg::*;

    // word index width, at least one bit
    localparam int IW = (WORDS_PER_CORE > 1) ? $clog2(WORDS_PER_CORE) : 1;

    // local operand store
    data_t       ops [WORDS_PER_CORE];

    lane_state_t state;
    logic        fin_q;
    logic        agu_start;
    logic        agu_en;
    logic [IW-1:0] idx;
    logic        idx_last;
    data_t       mac;

    // ========================================================================
    // operand capture
    // ========================================================================

    always_ff @(posedge clk) begin
        // only writes addressed to this lane
        if (op_wr.en && (op_wr.lane == 8'(LANE_ID))) begin
            ops[op_wr.word[IW-1:0]] <= op_wr.data;
        end
    end

    // ========================================================================
    // sequencing
    // ========================================================================

    assign agu_start = start && (state == LANE_IDLE);
    assign agu_en    = (state == LANE_RUN);

    agu #(
        .W        (IW),
        .LAST_IDX (WORDS_PER_CORE - 1)
    ) u_agu (
        .clk   (clk),
        .rst   (rst),
        .start (agu_start),
        .en    (agu_en),
        .data  (idx),
        .last  (idx_last)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LANE_IDLE;
            fin_q <= 1'b0;
        end else begin
            // pulse lines up with the FIN state
            fin_q <= (state == LANE_RUN) && idx_last;
            case (state)
                LANE_IDLE: if (start)    state <= LANE_RUN;
                LANE_RUN:  if (idx_last) state <= LANE_FIN;
                default:                 state <= LANE_IDLE;
            endcase
        end
    end

    // truncated to data width
    assign mac = data_t'(ops[idx] * cfg.coeff + cfg.offset);

    // one result per RUN cycle, held until the next start
    always_ff @(posedge clk) begin
        if (state == LANE_RUN) begin
            results[idx] <= mac;
        end
    end

    assign fin = fin_q;

endmodule

//--- design/stream_ctrl.sv
`timescale 1ns/10ps

module stream_ctrl #(
    parameter int NUM_CORES      = 4,
    parameter int WORDS_PER_CORE = 4
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [NUM_CORES-1:0]                                 lane_fin,
    input  stream_pkg::data_t [NUM_CORES*WORDS_PER_CORE-1:0]     results,
    input  logic                                                 dst_ready,
    output logic                                                 dst_valid,
    output logic                                                 dst_last,
    output stream_pkg::data_t                                    dst_data,
    output logic                                                 stream_done
);

    import stream_pkg::*;

    localparam int TOTAL = NUM_CORES * WORDS_PER_CORE;
    localparam int IW    = (TOTAL > 1) ? $clog2(TOTAL) : 1;

    logic          fin_q;
    logic          fin_keep;
    logic          stream_ok;
    logic          stream_ok_keep;
    logic          agu_start;
    logic          stream_active;
    logic [IW-1:0] idx;
    logic          last_stream;
    logic          done_q;

    // ========================================================================
    // finish capture
    // ========================================================================

    // all lanes start together, so their fin pulses coincide
    always_ff @(posedge clk) begin
        if (rst) begin
            fin_q <= 1'b0;
        end else begin
            fin_q <= &lane_fin;
        end
    end

    // hold the finish until a ready cycle takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            fin_keep <= 1'b0;
        end else if (stream_ok) begin
            fin_keep <= 1'b0;
        end else if (fin_q) begin
            fin_keep <= 1'b1;
        end
    end

    assign stream_ok = (fin_q | fin_keep) & dst_ready;

    // accepted finish, waits one more ready cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_ok_keep <= 1'b0;
        end else if (dst_ready) begin
            stream_ok_keep <= stream_ok;
        end
    end

    assign agu_start = dst_ready & stream_ok_keep;

    // ========================================================================
    // index walk
    // ========================================================================

    agu #(
        .W        (IW),
        .LAST_IDX (TOTAL - 1)
    ) u_agu (
        .clk   (clk),
        .rst   (rst),
        .start (agu_start),
        .en    (dst_ready),
        .data  (idx),
        .last  (last_stream)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            stream_active <= 1'b0;
        end else if (dst_ready) begin
            if (last_stream) begin
                stream_active <= 1'b0;
            end else if (agu_start) begin
                stream_active <= 1'b1;
            end
        end
    end

    // ========================================================================
    // output stage, moves only with dst_ready
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active & last_stream;
        end
    end

    // word select at the current index
    always_ff @(posedge clk) begin
        if (dst_ready) begin
            dst_data <= results[idx];
        end
    end

    // final word taken by the sink
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= dst_valid & dst_last & dst_ready;
        end
    end

    assign stream_done = done_q;

endmodule

//--- design/stream_top.sv
`timescale 1ns/10ps

module stream_top #(
    parameter int NUM_CORES      = 4,
    parameter int WORDS_PER_CORE = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  stream_pkg::wb_req_t wb_req,
    output stream_pkg::wb_rsp_t wb_rsp,
    input  logic                dst_ready,
    output logic                dst_valid,
    output logic                dst_last,
    output stream_pkg::data_t   dst_data
);

    import stream_pkg::*;

    localparam int TOTAL = NUM_CORES * WORDS_PER_CORE;

    logic                 start;
    lane_cfg_t            cfg;
    op_wr_t               op_wr;
    logic                 stream_done;
    logic [NUM_CORES-1:0] lane_fin;
    // lane l, word w sits at flat index l * WORDS_PER_CORE + w
    data_t [TOTAL-1:0]    results_all;

    // ========================================================================
    // host side
    // ========================================================================

    wb_regs #(
        .NUM_CORES      (NUM_CORES),
        .WORDS_PER_CORE (WORDS_PER_CORE)
    ) u_wb_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .stream_done (stream_done),
        .start       (start),
        .cfg         (cfg),
        .op_wr       (op_wr)
    );

    // ========================================================================
    // compute lanes
    // ========================================================================

    for (genvar l = 0; l < NUM_CORES; l++) begin : g_lane
        data_t [WORDS_PER_CORE-1:0] lane_res;

        core_lane #(
            .LANE_ID        (l),
            .WORDS_PER_CORE (WORDS_PER_CORE)
        ) u_core_lane (
            .clk     (clk),
            .rst     (rst),
            .start   (start),
            .cfg     (cfg),
            .op_wr   (op_wr),
            .fin     (lane_fin[l]),
            .results (lane_res)
        );

        assign results_all[l*WORDS_PER_CORE +: WORDS_PER_CORE] = lane_res;
    end

    // ========================================================================
    // result stream
    // ========================================================================

    stream_ctrl #(
        .NUM_CORES      (NUM_CORES),
        .WORDS_PER_CORE (WORDS_PER_CORE)
    ) u_stream_ctrl (
        .clk         (clk),
        .rst         (rst),
        .lane_fin    (lane_fin),
        .results     (results_all),
        .dst_ready   (dst_ready),
        .dst_valid   (dst_valid),
        .dst_last    (dst_last),
        .dst_data    (dst_data),
        .stream_done (stream_done)
    );

endmodule

//--- verification/tb_stream_top.sv
`timescale 1ns/10ps

module tb_stream_top;

    import stream_pkg::*;

    localparam int NUM_CORES      = 4;
    localparam int WORDS_PER_CORE = 4;
    localparam int TOTAL          = NUM_CORES * WORDS_PER_CORE;
    localparam int ACK_TIMEOUT    = 50;
    localparam int STREAM_TIMEOUT = 2000;
    localparam int POLL_TIMEOUT   = 100;

    logic    clk;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    dst_ready;
    logic    dst_valid;
    logic    dst_last;
    data_t   dst_data;

    // random source
    logic [31:0] lfsr = 32'h3a7c;

    // reference model state
    data_t ops_m [TOTAL];
    data_t coeff_m;
    data_t offset_m;

    // words seen by the monitor
    data_t rx_data [$];
    logic  rx_last [$];
    int    rx_cycle [$];

    int          errors         = 0;
    int          tests_run      = 0;
    int          tests_failed   = 0;
    int          test_err_start = 0;
    int          cyc_count      = 0;
    logic        prev_ready     = 1'b0;
    logic        hold_armed     = 1'b0;
    logic [17:0] prev_out;

    stream_top #(
        .NUM_CORES      (NUM_CORES),
        .WORDS_PER_CORE (WORDS_PER_CORE)
    ) u_stream_top (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .dst_data  (dst_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================================================
    // helpers
    // ========================================================================

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic report_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    // operand times coeff plus offset, low 16 bits
    function automatic data_t expected_word(input int k);
        logic [31:0] p;
        p = ops_m[k] * coeff_m + offset_m;
        return p[15:0];
    endfunction

    // classic cycle, called on a falling edge, returns on one
    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                             output wb_dat_t rdat);
        int cycles;
        cycles     = 0;
        rdat       = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge clk);
        while (!wb_rsp.ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_rsp.ack) begin
            $display("timeout: no ack for access to address %h", adr);
            errors++;
        end else begin
            rdat = wb_rsp.dat;
        end
        wb_req = '0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t wdat);
        wb_dat_t unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic load_operands();
        logic [31:0] r;
        for (int k = 0; k < TOTAL; k++) begin
            rand_bits(16, r);
            ops_m[k] = r[15:0];
            wb_write(REG_OPBASE + 8'(k), r[15:0]);
        end
    endtask

    task automatic start_run();
        wb_write(REG_CTRL, 16'(1 << CTRL_START));
    endtask

    task automatic clear_capture();
        rx_data.delete();
        rx_last.delete();
        rx_cycle.delete();
    endtask

    // optionally toggles ready while waiting
    task automatic wait_words(input bit rand_ready);
        logic [31:0] r;
        int          cycles;
        cycles = 0;
        while (rx_data.size() < TOTAL && cycles < STREAM_TIMEOUT) begin
            @(negedge clk);
            if (rand_ready) begin
                rand_bits(1, r);
                dst_ready = r[0];
            end
            cycles++;
        end
        if (rx_data.size() < TOTAL) begin
            $display("timeout: only %0d of %0d words received", rx_data.size(), TOTAL);
            errors++;
        end
    endtask

    // stream has started moving
    task automatic wait_first_word();
        int cycles;
        cycles = 0;
        while (rx_data.size() == 0 && cycles < STREAM_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rx_data.size() == 0) begin
            $display("timeout: no stream word received");
            errors++;
        end
    endtask

    task automatic wait_done();
        wb_dat_t rd;
        int      polls;
        polls = 0;
        rd    = '0;
        while (!rd[CTRL_DONE] && polls < POLL_TIMEOUT) begin
            wb_read(REG_CTRL, rd);
            polls++;
        end
        if (!rd[CTRL_DONE]) begin
            $display("timeout: done flag still clear after %0d status reads", polls);
            errors++;
        end
    endtask

    // order, values, last flag, and gap-free timing if asked
    task automatic check_stream(input bit back_to_back);
        data_t exp;
        if (rx_data.size() != TOTAL) begin
            report_fail($sformatf("received %0d words, expected %0d", rx_data.size(), TOTAL));
        end
        for (int k = 0; k < TOTAL && k < rx_data.size(); k++) begin
            exp = expected_word(k);
            if (rx_data[k] !== exp) begin
                report_fail($sformatf("word %0d is %h, expected %h", k, rx_data[k], exp));
            end
            if (rx_last[k] !== (k == TOTAL - 1)) begin
                report_fail($sformatf("word %0d has last %b", k, rx_last[k]));
            end
            if (back_to_back && rx_cycle[k] != rx_cycle[0] + k) begin
                report_fail($sformatf("word %0d not on consecutive cycle", k));
            end
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - test_err_start;
        tests_run++;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, n);
        end
        test_err_start = errors;
    endtask

    // ========================================================================
    // output monitor
    // ========================================================================

    always @(posedge clk) begin
        cyc_count++;
        if (!rst && dst_valid && dst_ready) begin
            rx_data.push_back(dst_data);
            rx_last.push_back(dst_last);
            rx_cycle.push_back(cyc_count);
        end
        // stalled cycle, outputs must not move
        if (hold_armed && !prev_ready && {dst_valid, dst_last, dst_data} !== prev_out) begin
            report_fail("stream output changed while dst_ready was low");
        end
        prev_out   = {dst_valid, dst_last, dst_data};
        prev_ready = dst_ready;
        hold_armed = !rst;
    end

    // ========================================================================
    // test sequence
    // ========================================================================

    initial begin
        wb_dat_t     rd;
        logic [31:0] r;
        rst       = 1'b1;
        wb_req    = '0;
        dst_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle outputs and clear status
        if (dst_valid !== 1'b0 || dst_last !== 1'b0) begin
            report_fail("dst_valid or dst_last not low after reset");
        end
        wb_read(REG_CTRL, rd);
        if (rd[CTRL_BUSY] !== 1'b0 || rd[CTRL_DONE] !== 1'b0) begin
            report_fail($sformatf("ctrl reads %h after reset", rd));
        end
        end_test("1 reset state");

        rand_bits(16, r);
        coeff_m = r[15:0];
        rand_bits(16, r);
        offset_m = r[15:0];
        wb_write(REG_COEFF, coeff_m);
        wb_write(REG_OFFSET, offset_m);
        wb_read(REG_COEFF, rd);
        if (rd !== coeff_m) begin
            report_fail($sformatf("coeff reads %h, wrote %h", rd, coeff_m));
        end
        wb_read(REG_OFFSET, rd);
        if (rd !== offset_m) begin
            report_fail($sformatf("offset reads %h, wrote %h", rd, offset_m));
        end
        end_test("2 register readback");

        load_operands();
        clear_capture();
        dst_ready = 1'b1;
        start_run();
        wait_words(1'b0);
        wait_done();
        check_stream(1'b1);
        end_test("3 continuous ready");

        load_operands();
        clear_capture();
        rand_bits(1, r);
        dst_ready = r[0];
        start_run();
        wait_words(1'b1);
        dst_ready = 1'b1;
        wait_done();
        check_stream(1'b0);
        end_test("4 back-pressure");

        // sink stalled so the run stays busy
        clear_capture();
        dst_ready = 1'b0;
        start_run();
        wb_read(REG_CTRL, rd);
        if (rd[CTRL_BUSY] !== 1'b1 || rd[CTRL_DONE] !== 1'b0) begin
            report_fail($sformatf("ctrl reads %h during run", rd));
        end
        dst_ready = 1'b1;
        // lanes back in idle while words flow
        wait_first_word();
        // ignored second start
        start_run();
        wait_words(1'b0);
        wait_done();
        check_stream(1'b0);
        wb_read(REG_CTRL, rd);
        if (rd[CTRL_BUSY] !== 1'b0 || rd[CTRL_DONE] !== 1'b1) begin
            report_fail($sformatf("ctrl reads %h after run", rd));
        end
        // quiet window, no second stream
        repeat (4 * TOTAL) @(negedge clk);
        if (rx_data.size() != TOTAL) begin
            report_fail($sformatf("%0d words after ignored start", rx_data.size()));
        end
        end_test("5 status flags");

        // new coeff, same operands
        rand_bits(16, r);
        coeff_m = coeff_m ^ (r[15:0] | 16'h0001);
        wb_write(REG_COEFF, coeff_m);
        clear_capture();
        start_run();
        wait_words(1'b0);
        wait_done();
        check_stream(1'b1);
        end_test("6 back-to-back run");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
design/stream_pkg.sv
design/agu.sv
design/wb_regs.sv
design/core_lane.sv
design/stream_ctrl.sv
design/stream_top.sv
verification/tb_stream_top.sv

//--- Makefile
# Verilator build and run for the stream_top testbench
# any variable can be overridden, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_stream_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv) $(wildcard verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
